/* bench/conv_sva.sv */
// protocol assertions for the convolution engine
// output hold under back-pressure, one-cycle done pulse, no input while computing

`timescale 1ns/10ps
`default_nettype none

module conv_sva (
  input logic                   clk,
  input logic                   rstn,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input conv_pkg::stream_word_t out_word,
  input logic                   conv_done,
  input logic                   mac_busy,
  input conv_pkg::conv_state_e  state
);

  // a stalled word must not move
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else $error("out_word changed while out_ready was low");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    conv_done |=> !conv_done)
    else $error("conv_done held longer than one cycle");

  // no input word while taps go out or still sit in the MAC
  a_no_input_compute: assert property (@(posedge clk) disable iff (!rstn)
    ((state == conv_pkg::COMPUTE) || mac_busy) |-> !in_ready)
    else $error("in_ready high while the engine was computing");

endmodule

bind conv_top conv_sva u_sva (
  .clk       (clk),
  .rstn      (rstn),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_word  (out_word),
  .conv_done (conv_done),
  .mac_busy  (mac_busy),
  .state     (u_ctrl.state_q)
);

`default_nettype wire

/* bench/conv_tb.sv */
// testbench for the 3x3 convolution engine
// runs a table of cases through conv_top and compares every output word
// with a reference model of the zero-padded convolution and requantization

`timescale 1ns/10ps
`default_nettype none

module conv_tb;

  localparam int FMAP_LEN = 8;
  localparam int NPIX     = FMAP_LEN * FMAP_LEN;
  localparam int NWORDS   = NPIX / 4;
  localparam int NCASES   = 6;
  localparam int TIMEOUT  = 4000;  // cycles allowed per wait

  localparam logic [1:0] FEAT_RAMP  = 2'd0;  // -128, -124, ... 124
  localparam logic [1:0] FEAT_CONST = 2'd1;
  localparam logic [1:0] FEAT_RAND  = 2'd2;

  typedef struct packed {
    logic [1:0]      kind;
    logic [7:0]      fill;       // value of a constant map
    logic            rand_coef;  // random weights and bias
    logic [8:0][7:0] wgt;        // wgt[0] is the top-left tap
    logic [7:0]      bias;
    logic [7:0]      gap_pct;
    logic [7:0]      stall_pct;
    logic            check;
  } case_t;

  logic                   clk, rstn, conv_start, in_valid, out_ready;
  logic                   in_ready, out_valid, conv_done;
  conv_pkg::stream_word_t in_word, out_word;

  case_t             cases [NCASES];
  logic signed [7:0] fmap [NPIX];
  logic signed [7:0] wgt [9];
  logic signed [7:0] bias;
  logic [31:0]       got [NWORDS];
  integer            seed;
  int                errors, checks, done_cnt;
  logic              aborted;

  conv_top #(.FMAP_LEN(FMAP_LEN)) UUT (
    .clk        (clk),
    .rstn       (rstn),
    .conv_start (conv_start),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_ready  (out_ready),
    .conv_done  (conv_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rstn && conv_done) done_cnt++;  // sampled mid-cycle
  end

  ////////////////////////////////////////////////////////////
  // checking helpers and reference model
  ////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
  endtask

  function automatic logic chance(input logic [7:0] pct);
    int r;
    r = $random(seed);
    return ($unsigned(r) % 100) < 32'(pct);
  endfunction

  function automatic logic [7:0] model_pixel(input int r, input int c);
    int sum, rr, cc;
    sum = int'(bias) * 64;  // bias aligned at bit 6
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        rr = r + dy;
        cc = c + dx;
        if (rr >= 0 && rr < FMAP_LEN && cc >= 0 && cc < FMAP_LEN) begin
          sum += int'(fmap[rr*FMAP_LEN + cc]) * int'(wgt[(dy+1)*3 + dx + 1]);
        end
      end
    end
    if (sum < 0) return 8'd0;
    if (sum >= 8192) return 8'd127;  // something at bit 13 or above
    return 8'(sum / 64);
  endfunction

  function automatic logic [31:0] expected_word(input int w);
    logic [31:0] word;
    int p;
    for (int k = 0; k < 4; k++) begin
      p = 4*w + k;
      word[8*k +: 8] = model_pixel(p / FMAP_LEN, p % FMAP_LEN);
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic prepare(input case_t c);
    for (int i = 0; i < NPIX; i++) begin
      case (c.kind)
        FEAT_RAMP:  fmap[i] = 8'(i * 4 - 128);
        FEAT_CONST: fmap[i] = c.fill;
        default:    fmap[i] = 8'($random(seed));
      endcase
    end
    for (int k = 0; k < 9; k++) begin
      wgt[k] = c.rand_coef ? 8'($random(seed)) : c.wgt[k];
    end
    bias = c.rand_coef ? 8'($random(seed)) : c.bias;
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_word(input logic [31:0] data, input logic [7:0] gap_pct);
    int n;
    if (!aborted) begin
      in_valid = 1'b0;
      if (chance(gap_pct)) @(negedge clk);
      in_valid     = 1'b1;
      in_word.data = data;
      in_word.last = 1'b0;
      n = 0;
      while (!in_ready && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!in_ready) report_timeout("input ready");
      else @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic feed(input logic [7:0] gap_pct);
    for (int w = 0; w < NWORDS; w++) begin
      send_word({fmap[4*w+3], fmap[4*w+2], fmap[4*w+1], fmap[4*w]}, gap_pct);
    end
    send_word({wgt[3], wgt[2], wgt[1], wgt[0]}, gap_pct);
    send_word({wgt[7], wgt[6], wgt[5], wgt[4]}, gap_pct);
    send_word({24'h5a5a5a, wgt[8]}, gap_pct);  // upper bytes are don't-care
    send_word({24'ha5a5a5, bias}, gap_pct);
  endtask

  task automatic collect(input logic [7:0] stall_pct);
    int n;
    for (int w = 0; w < NWORDS && !aborted; w++) begin
      n = 0;
      out_ready = !chance(stall_pct);
      while (!(out_valid && out_ready) && n < TIMEOUT) begin
        @(negedge clk);
        out_ready = !chance(stall_pct);
        n++;
      end
      if (!(out_valid && out_ready)) begin
        report_timeout("output word");
      end else begin
        got[w] = out_word.data;
        check("out_word.last", 32'(w == NWORDS - 1), 32'(out_word.last));
        @(negedge clk);  // word taken on the rising edge in between
      end
    end
    out_ready = 1'b0;
    // done follows the last handshake by one cycle
    if (!aborted) begin
      check("conv_done", 32'd1, 32'(conv_done));
      @(negedge clk);
      check("conv_done", 32'd0, 32'(conv_done));
    end
  endtask

  task automatic run_case(input int idx);
    case_t c;
    c = cases[idx];
    prepare(c);
    conv_start = 1'b1;
    @(negedge clk);
    conv_start = 1'b0;
    fork
      feed(c.gap_pct);
      collect(c.stall_pct);
    join
    if (c.check && !aborted) begin
      for (int w = 0; w < NWORDS; w++) begin
        check($sformatf("out_word.data[%0d] case %0d", w, idx), expected_word(w), got[w]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed       = 32'h3ae8d11d;
    errors     = 0;
    checks     = 0;
    done_cnt   = 0;
    aborted    = 1'b0;
    rstn       = 1'b0;
    conv_start = 1'b0;
    in_valid   = 1'b0;
    in_word    = '0;
    out_ready  = 1'b0;

    cases[0] = '{kind: FEAT_RAMP, fill: 8'd0, rand_coef: 1'b0,
                 wgt: {8'd0, 8'd0, 8'd0, 8'd0, 8'd64, 8'd0, 8'd0, 8'd0, 8'd0},
                 bias: 8'd0, gap_pct: 8'd0, stall_pct: 8'd0, check: 1'b1};  // identity
    cases[1] = '{kind: FEAT_CONST, fill: 8'd64, rand_coef: 1'b0, wgt: {9{8'd1}},
                 bias: 8'd0, gap_pct: 8'd0, stall_pct: 8'd0, check: 1'b1};  // padding
    cases[2] = '{kind: FEAT_CONST, fill: 8'd100, rand_coef: 1'b0, wgt: {9{8'd100}},
                 bias: 8'h7f, gap_pct: 8'd0, stall_pct: 8'd0, check: 1'b1}; // clamp high
    cases[3] = '{kind: FEAT_CONST, fill: 8'd10, rand_coef: 1'b0, wgt: {9{8'd1}},
                 bias: 8'h80, gap_pct: 8'd0, stall_pct: 8'd0, check: 1'b1}; // clamp low
    cases[4] = '{kind: FEAT_RAND, fill: 8'd0, rand_coef: 1'b1, wgt: '0,
                 bias: 8'd0, gap_pct: 8'd0, stall_pct: 8'd0, check: 1'b1};
    cases[5] = '{kind: FEAT_RAND, fill: 8'd0, rand_coef: 1'b1, wgt: '0,
                 bias: 8'd0, gap_pct: 8'd30, stall_pct: 8'd40, check: 1'b1};

    repeat (8) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check("in_ready", 32'd0, 32'(in_ready));
    check("out_valid", 32'd0, 32'(out_valid));
    check("conv_done", 32'd0, 32'(conv_done));

    for (int i = 0; i < NCASES && !aborted; i++) begin
      run_case(i);
      repeat (3) @(negedge clk);
      check("conv_done pulse count", 32'(i + 1), 32'(done_cnt));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
design/conv_pkg.sv
design/cla_adder.sv
design/mult_pipe.sv
design/mac_unit.sv
design/fmap_buffer.sv
design/conv_ctrl.sv
design/out_pack.sv
design/conv_top.sv
bench/conv_sva.sv
bench/conv_tb.sv

/* design/cla_adder.sv */
// carry-lookahead adder
// 4-bit groups with their own bit-level carry chain, and a lookahead
// chain over the group propagate/generate pairs for the group carry-ins

`timescale 1ns/10ps
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 20   // multiple of 4
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p, g;
  logic [NG-1:0]    grp_p, grp_g;
  logic [NG:0]      grp_c;  // carry into each group

  assign p = a ^ b;
  assign g = a & b;

  assign grp_c[0] = 1'b0;  // add only

  for (genvar k = 0; k < NG; k++) begin : g_grp
    logic [3:0] gp, gg;
    logic [4:0] c;

    assign gp = p[4*k +: 4];
    assign gg = g[4*k +: 4];

    // local ripple inside the group
    assign c[0] = grp_c[k];
    for (genvar i = 0; i < 4; i++) begin : g_bit
      assign c[i+1] = gg[i] | (gp[i] & c[i]);
    end

    assign grp_p[k] = &gp;
    assign grp_g[k] = gg[3] | (gg[2] & gp[3]) | (gg[1] & gp[2] & gp[3])
                    | (gg[0] & gp[1] & gp[2] & gp[3]);

    assign grp_c[k+1] = grp_g[k] | (grp_p[k] & grp_c[k]);  // lookahead across groups
    assign sum[4*k +: 4] = gp ^ c[3:0];
  end

endmodule

`default_nettype wire

/* design/conv_ctrl.sv */
// convolution controller
// run FSM: loads the feature map and coefficients from the input stream,
// then walks the output pixels in raster order and issues nine taps each

`timescale 1ns/10ps
`default_nettype none

module conv_ctrl #(
  parameter  int FMAP_LEN = 8,
  localparam int NW       = FMAP_LEN * FMAP_LEN / 4,
  localparam int IDX_W    = $clog2(NW),
  localparam int COORD_W  = $clog2(FMAP_LEN) + 2
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          conv_start,
  input  logic                          in_valid,
  input  conv_pkg::stream_word_t        in_word,
  output logic                          in_ready,
  output logic                          wr_en,
  output logic [IDX_W-1:0]              wr_index,
  output logic [conv_pkg::WORD_W-1:0]   wr_data,
  output logic signed [COORD_W-1:0]     rd_row,
  output logic signed [COORD_W-1:0]     rd_col,
  input  logic [conv_pkg::PIX_W-1:0]    rd_pix,
  output logic                          tap_valid,
  output conv_pkg::tap_t                tap,
  input  logic                          mac_busy,
  input  logic                          pix_ready,
  output logic [conv_pkg::PIX_W-1:0]    bias
);

  localparam int LOG_W = $clog2(FMAP_LEN);

  conv_pkg::conv_state_e state_q;
  logic [IDX_W-1:0]      cnt_q;       // word count in both load phases
  logic [LOG_W-1:0]      pr_q, pc_q;  // output pixel row/col
  logic [1:0]            ty_q, tx_q;  // tap offset + 1
  logic                  active_q;    // taps of a pixel going out
  logic                  in_fire, last_tap;
  logic [3:0]            tap_idx;
  logic [conv_pkg::TAPS-1:0][conv_pkg::PIX_W-1:0] wgt_q;
  logic [conv_pkg::PIX_W-1:0]                     bias_q;

  assign in_ready = (state_q == conv_pkg::LOAD_FMAP) || (state_q == conv_pkg::LOAD_COEF);
  assign in_fire  = in_valid && in_ready;
  assign wr_en    = in_fire && (state_q == conv_pkg::LOAD_FMAP);
  assign wr_index = cnt_q;
  assign wr_data  = in_word.data;

  assign rd_row   = COORD_W'(pr_q) + COORD_W'(ty_q) - 1'b1;
  assign rd_col   = COORD_W'(pc_q) + COORD_W'(tx_q) - 1'b1;
  assign tap_idx  = 4'(ty_q) * 4'd3 + 4'(tx_q);  // row-major weight index
  assign last_tap = (ty_q == 2'd2) && (tx_q == 2'd2);
  assign bias     = bias_q;

  ////////////////////////////////////////////////////////////
  // phase FSM and tap sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q   <= conv_pkg::IDLE;
      cnt_q     <= '0;
      pr_q      <= '0;
      pc_q      <= '0;
      ty_q      <= '0;
      tx_q      <= '0;
      active_q  <= 1'b0;
      tap_valid <= 1'b0;
    end else begin
      tap_valid <= active_q;
      case (state_q)
        conv_pkg::IDLE: begin
          cnt_q <= '0;
          if (conv_start) state_q <= conv_pkg::LOAD_FMAP;
        end
        conv_pkg::LOAD_FMAP: begin
          if (in_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == IDX_W'(NW - 1)) begin
              cnt_q   <= '0;
              state_q <= conv_pkg::LOAD_COEF;
            end
          end
        end
        conv_pkg::LOAD_COEF: begin
          if (in_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == IDX_W'(3)) begin  // bias word closes the load
              cnt_q   <= '0;
              pr_q    <= '0;
              pc_q    <= '0;
              state_q <= conv_pkg::COMPUTE;
            end
          end
        end
        conv_pkg::COMPUTE: begin
          if (!active_q) begin
            // pixel boundary, wait for room downstream
            if (pix_ready && !mac_busy) active_q <= 1'b1;
          end else if (last_tap) begin
            active_q <= 1'b0;
            ty_q     <= '0;
            tx_q     <= '0;
            if (pc_q == LOG_W'(FMAP_LEN - 1)) begin
              pc_q <= '0;
              if (pr_q == LOG_W'(FMAP_LEN - 1)) begin
                pr_q    <= '0;
                state_q <= conv_pkg::DRAIN;
              end else begin
                pr_q <= pr_q + 1'b1;
              end
            end else begin
              pc_q <= pc_q + 1'b1;
            end
          end else if (tx_q == 2'd2) begin
            tx_q <= '0;
            ty_q <= ty_q + 1'b1;
          end else begin
            tx_q <= tx_q + 1'b1;
          end
        end
        conv_pkg::DRAIN: begin
          if (!mac_busy) state_q <= conv_pkg::IDLE;
        end
        default: state_q <= conv_pkg::IDLE;
      endcase
    end
  end

  // coefficients and tap payload
  always_ff @(posedge clk) begin
    if (in_fire && (state_q == conv_pkg::LOAD_COEF)) begin
      case (cnt_q[1:0])
        2'd0:    wgt_q[3:0] <= in_word.data;
        2'd1:    wgt_q[7:4] <= in_word.data;
        2'd2:    wgt_q[8]   <= in_word.data[conv_pkg::PIX_W-1:0];  // upper bytes unused
        default: bias_q     <= in_word.data[conv_pkg::PIX_W-1:0];
      endcase
    end
    tap.feat   <= rd_pix;
    tap.weight <= wgt_q[tap_idx];
    tap.first  <= (ty_q == 2'd0) && (tx_q == 2'd0);
    tap.last   <= last_tap;
  end

endmodule

`default_nettype wire

/* design/conv_pkg.sv */
// conv package
// widths, stream and tap structs and the FSM states shared by the
// 3x3 convolution engine

`default_nettype none

package conv_pkg;

  localparam int WORD_W      = 32;  // stream word
  localparam int PIX_W       = 8;   // pixel and weight
  localparam int ACC_W       = 20;  // nine full-scale products plus bias
  localparam int TAPS        = 9;
  localparam int BIAS_SHIFT  = 6;
  localparam int MULT_STAGES = 4;

  // one stream beat
  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } stream_word_t;

  // one multiply request toward the MAC
  typedef struct packed {
    logic [PIX_W-1:0] feat;
    logic [PIX_W-1:0] weight;
    logic             first;   // restarts the accumulator
    logic             last;    // closes the output pixel
  } tap_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_FMAP,
    LOAD_COEF,
    COMPUTE,
    DRAIN
  } conv_state_e;

endpackage

`default_nettype wire

/* design/conv_top.sv */
// 3x3 convolution engine top level
// connects the controller, feature buffer, MAC and output packer

`timescale 1ns/10ps
`default_nettype none

module conv_top #(
  parameter int FMAP_LEN = 8
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    conv_start,
  input  logic                    in_valid,
  input  conv_pkg::stream_word_t  in_word,
  output logic                    in_ready,
  output logic                    out_valid,
  output conv_pkg::stream_word_t  out_word,
  input  logic                    out_ready,
  output logic                    conv_done
);

  localparam int IDX_W   = $clog2(FMAP_LEN * FMAP_LEN / 4);
  localparam int COORD_W = $clog2(FMAP_LEN) + 2;

  logic                        wr_en;
  logic [IDX_W-1:0]            wr_index;
  logic [conv_pkg::WORD_W-1:0] wr_data;
  logic signed [COORD_W-1:0]   rd_row, rd_col;
  logic [conv_pkg::PIX_W-1:0]  rd_pix, bias;
  logic                        tap_valid, mac_busy, pix_ready, acc_valid;
  conv_pkg::tap_t              tap;
  conv_pkg::acc_t              acc;

  conv_ctrl #(.FMAP_LEN(FMAP_LEN)) u_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .conv_start (conv_start),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .in_ready   (in_ready),
    .wr_en      (wr_en),
    .wr_index   (wr_index),
    .wr_data    (wr_data),
    .rd_row     (rd_row),
    .rd_col     (rd_col),
    .rd_pix     (rd_pix),
    .tap_valid  (tap_valid),
    .tap        (tap),
    .mac_busy   (mac_busy),
    .pix_ready  (pix_ready),
    .bias       (bias)
  );

  fmap_buffer #(.FMAP_LEN(FMAP_LEN)) u_fmap (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .rd_row   (rd_row),
    .rd_col   (rd_col),
    .rd_pix   (rd_pix)
  );

  mac_unit u_mac (
    .clk       (clk),
    .rstn      (rstn),
    .tap_valid (tap_valid),
    .tap       (tap),
    .busy      (mac_busy),
    .acc_valid (acc_valid),
    .acc       (acc)
  );

  out_pack #(.FMAP_LEN(FMAP_LEN)) u_pack (
    .clk       (clk),
    .rstn      (rstn),
    .acc_valid (acc_valid),
    .acc       (acc),
    .bias      (bias),
    .pix_ready (pix_ready),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_ready (out_ready),
    .conv_done (conv_done)
  );

endmodule

`default_nettype wire

/* design/fmap_buffer.sv */
// feature map buffer
// byte array written a word at a time, read one byte combinationally at
// a signed row/column with zero returned off the map

`timescale 1ns/10ps
`default_nettype none

module fmap_buffer #(
  parameter  int FMAP_LEN = 8,
  localparam int NW       = FMAP_LEN * FMAP_LEN / 4,
  localparam int IDX_W    = $clog2(NW),
  localparam int COORD_W  = $clog2(FMAP_LEN) + 2
) (
  input  logic                          clk,
  input  logic                          wr_en,
  input  logic [IDX_W-1:0]              wr_index,
  input  logic [conv_pkg::WORD_W-1:0]   wr_data,
  input  logic signed [COORD_W-1:0]     rd_row,
  input  logic signed [COORD_W-1:0]     rd_col,
  output logic [conv_pkg::PIX_W-1:0]    rd_pix
);

  localparam int NPIX   = FMAP_LEN * FMAP_LEN;
  localparam int ADDR_W = $clog2(NPIX);

  logic [conv_pkg::PIX_W-1:0] mem [NPIX];
  logic [ADDR_W-1:0]          rd_addr;
  logic                       in_map;

  // lowest byte is the first pixel of the word
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        mem[{wr_index, 2'(i)}] <= wr_data[8*i +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // window read with zero padding
  ////////////////////////////////////////////////////////////
  assign in_map = (rd_row >= 0) && (rd_row < FMAP_LEN)
               && (rd_col >= 0) && (rd_col < FMAP_LEN);

  assign rd_addr = ADDR_W'(int'(rd_row) * FMAP_LEN + int'(rd_col));

  always_comb begin
    rd_pix = '0;
    if (in_map) rd_pix = mem[rd_addr];
  end

endmodule

`default_nettype wire

/* design/mac_unit.sv */
// multiply-accumulate unit
// multiplies each tap and accumulates the nine taps of one output pixel,
// restarting on the first-tap flag

`timescale 1ns/10ps
`default_nettype none

module mac_unit (
  input  logic            clk,
  input  logic            rstn,
  input  logic            tap_valid,
  input  conv_pkg::tap_t  tap,
  output logic            busy,
  output logic            acc_valid,
  output conv_pkg::acc_t  acc
);

  localparam int PW = 2 * conv_pkg::PIX_W;
  localparam int CW = $clog2(conv_pkg::TAPS + 1);

  logic                 mp_valid, mp_first, mp_last;
  logic signed [PW-1:0] mp_prod;
  conv_pkg::acc_t       acc_q, prod_ext, addend, acc_next;
  logic [CW-1:0]        inflight_q;  // taps issued but not accumulated

  mult_pipe u_mult (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (tap_valid),
    .a         (tap.feat),
    .b         (tap.weight),
    .first_in  (tap.first),
    .last_in   (tap.last),
    .out_valid (mp_valid),
    .product   (mp_prod),
    .first_out (mp_first),
    .last_out  (mp_last)
  );

  assign prod_ext = {{(conv_pkg::ACC_W-PW){mp_prod[PW-1]}}, mp_prod};
  assign addend   = mp_first ? '0 : acc_q;

  cla_adder #(.WIDTH(conv_pkg::ACC_W)) u_acc_add (
    .a   (prod_ext),
    .b   (addend),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      inflight_q <= '0;
      acc_valid  <= 1'b0;
    end else begin
      case ({tap_valid, mp_valid})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
      acc_valid <= mp_valid & mp_last;
    end
  end

  always_ff @(posedge clk) begin
    if (mp_valid) acc_q <= acc_next;
    if (mp_valid && mp_last) acc <= acc_next;  // finished pixel sum
  end

  assign busy = |inflight_q;

endmodule

`default_nettype wire

/* design/mult_pipe.sv */
// pipelined signed 8x8 multiplier
// sign-magnitude form: AND-selected partial products of the magnitudes are
// summed in pairs, then quads, then finally, and the sign is restored last

`timescale 1ns/10ps
`default_nettype none

module mult_pipe (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                in_valid,
  input  logic [conv_pkg::PIX_W-1:0]          a,
  input  logic [conv_pkg::PIX_W-1:0]          b,
  input  logic                                first_in,
  input  logic                                last_in,
  output logic                                out_valid,
  output logic signed [2*conv_pkg::PIX_W-1:0] product,
  output logic                                first_out,
  output logic                                last_out
);

  localparam int W  = conv_pkg::PIX_W;
  localparam int NS = conv_pkg::MULT_STAGES;

  logic [W-1:0]          a_mag, b_mag;
  logic [W-1:0][W-1:0]   pp_q;    // stage 1
  logic [3:0][W+1:0]     s2_q;    // stage 2, pair sums
  logic [1:0][W+3:0]     s3_q;    // stage 3, quad sums
  logic [2*W-1:0]        mag_sum;
  logic [NS-2:0]         sgn_q;
  logic [NS-1:0]         vld_q, fst_q, lst_q;

  assign a_mag = a[W-1] ? (~a + 1'b1) : a;
  assign b_mag = b[W-1] ? (~b + 1'b1) : b;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < W; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
    for (int j = 0; j < 4; j++) begin
      s2_q[j] <= (W+2)'(pp_q[2*j]) + {pp_q[2*j+1], 1'b0};
    end
    for (int k = 0; k < 2; k++) begin
      s3_q[k] <= (W+4)'(s2_q[2*k]) + {s2_q[2*k+1], 2'b00};
    end
    product <= sgn_q[NS-2] ? -$signed(mag_sum) : $signed(mag_sum);
    sgn_q   <= {sgn_q[NS-3:0], a[W-1] ^ b[W-1]};
    fst_q   <= {fst_q[NS-2:0], first_in};
    lst_q   <= {lst_q[NS-2:0], last_in};
  end

  assign mag_sum = (2*W)'(s3_q[0]) + {s3_q[1], 4'b0000};

  // valid flag, one bit per stage
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[NS-2:0], in_valid};
    end
  end

  assign out_valid = vld_q[NS-1];
  assign first_out = fst_q[NS-1];
  assign last_out  = lst_q[NS-1];

endmodule

`default_nettype wire

/* design/out_pack.sv */
// output packer
// adds the aligned bias, requantizes to 0..127, packs four results per
// word and drives the output stream with last on the final word

`timescale 1ns/10ps
`default_nettype none

module out_pack #(
  parameter int FMAP_LEN = 8
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        acc_valid,
  input  conv_pkg::acc_t              acc,
  input  logic [conv_pkg::PIX_W-1:0]  bias,
  output logic                        pix_ready,
  output logic                        out_valid,
  output conv_pkg::stream_word_t      out_word,
  input  logic                        out_ready,
  output logic                        conv_done
);

  localparam int NWORDS = FMAP_LEN * FMAP_LEN / 4;
  localparam int WC_W   = $clog2(NWORDS);
  localparam int AW     = conv_pkg::ACC_W;
  localparam int PW     = conv_pkg::PIX_W;
  localparam int SH     = conv_pkg::BIAS_SHIFT;

  conv_pkg::acc_t              bias_ext, biased;
  logic [PW-1:0]               q_pix;
  logic [conv_pkg::WORD_W-1:0] data_q;
  logic [1:0]                  lane_q;
  logic [WC_W-1:0]             wcnt_q;
  logic                        last_q;

  assign bias_ext = {{(AW-PW-SH){bias[PW-1]}}, bias, {SH{1'b0}}};

  cla_adder #(.WIDTH(AW)) u_bias_add (
    .a   (acc),
    .b   (bias_ext),
    .sum (biased)
  );

  // negative -> 0, anything at bit 13 or above -> 127, else bits 12:6
  always_comb begin
    if (biased[AW-1])          q_pix = '0;
    else if (|biased[AW-2:13]) q_pix = PW'(127);
    else                       q_pix = {1'b0, biased[12:6]};
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane_q    <= '0;
      wcnt_q    <= '0;
      out_valid <= 1'b0;
      last_q    <= 1'b0;
      conv_done <= 1'b0;
    end else begin
      conv_done <= out_valid && out_ready && last_q;
      if (acc_valid) begin
        lane_q <= lane_q + 1'b1;
        if (lane_q == 2'd3) begin
          out_valid <= 1'b1;
          last_q    <= (wcnt_q == WC_W'(NWORDS - 1));
        end
      end
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        wcnt_q    <= last_q ? '0 : wcnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) data_q[8*lane_q +: 8] <= q_pix;  // first pixel in low byte
  end

  // no byte lands while a full word waits, so data_q holds steady
  assign out_word.data = data_q;
  assign out_word.last = last_q;
  assign pix_ready     = !out_valid && !(acc_valid && (lane_q == 2'd3));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log &&
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
  -f build.f > run.log 2>&1 &&
./obj_dir/Vconv_tb >> run.log 2>&1 ||
echo "build or simulation stopped early, see run.log"
grep -q 'All tests passed!' run.log && echo "PASS" || { echo "FAIL"; exit 1; }
